// File: sim/mm_accel_checker.sv
`timescale 1ns/1ns
`default_nettype none
// protocol assertions for the accelerator top
// payload hold under stall, single-cycle done, wlast on beat 16 only
module mm_accel_checker (
    input wire                  clk,
    input wire                  rst_n,
    input wire                  arvalid_i,
    input wire mm_pkg::addr_t   araddr_i,
    input wire mm_pkg::axi_id_t arid_i,
    input wire                  arready_i,
    input wire                  awvalid_i,
    input wire mm_pkg::addr_t   awaddr_i,
    input wire                  awready_i,
    input wire                  wvalid_i,
    input wire mm_pkg::word_t   wdata_i,
    input wire                  wlast_i,
    input wire                  wready_i,
    input wire                  done_i
);

    // accepted w beats in the current burst
    mm_pkg::beat_cnt_t w_beats;
    // failed assertions so far
    int                fail_count = 0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_beats <= '0;
        end else if (wvalid_i && wready_i) begin
            w_beats <= wlast_i ? '0 : w_beats + 4'd1;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i) && $stable(arid_i))
        else begin
            $error("AR valid or payload changed while stalled");
            fail_count++;
        end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
        else begin
            $error("AW valid or payload changed while stalled");
            fail_count++;
        end

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wlast_i))
        else begin
            $error("W valid or payload changed while stalled");
            fail_count++;
        end

    // wlast exactly on the sixteenth beat
    w_last: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_i |-> (wlast_i == (w_beats == 4'd15)))
        else begin
            $error("wlast does not match the beat position");
            fail_count++;
        end

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |=> !done_i)
        else begin
            $error("done lasted more than one cycle");
            fail_count++;
        end

endmodule

bind mm_accel_top mm_accel_checker chk0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .arvalid_i (arvalid_o),
    .araddr_i  (araddr_o),
    .arid_i    (arid_o),
    .arready_i (arready_i),
    .awvalid_i (awvalid_o),
    .awaddr_i  (awaddr_o),
    .awready_i (awready_i),
    .wvalid_i  (wvalid_o),
    .wdata_i   (wdata_o),
    .wlast_i   (wlast_o),
    .wready_i  (wready_i),
    .done_i    (done_o)
);
`default_nettype wire

// File: sim/tb_mm_accel.sv
`timescale 1ns/1ns
`default_nettype none
// testbench for the matrix multiply accelerator
// random AXI memory model with stalls and interleaved R beats over eight checked jobs
module tb_mm_accel;

    localparam int          TIMEOUT = 4000;
    localparam logic [31:0] SEED    = 32'he854beee;

    logic            clk;
    logic            rst_n;
    mm_pkg::addr_t   mat_a_addr_i;
    mm_pkg::addr_t   mat_b_addr_i;
    mm_pkg::addr_t   mat_c_addr_i;
    logic            start_i;
    wire             done_o;
    wire             arvalid_o;
    mm_pkg::addr_t   araddr_o;
    mm_pkg::axi_id_t arid_o;
    logic            arready_i;
    logic            rvalid_i;
    mm_pkg::word_t   rdata_i;
    mm_pkg::axi_id_t rid_i;
    logic            rlast_i;
    wire             rready_o;
    wire             awvalid_o;
    mm_pkg::addr_t   awaddr_o;
    logic            awready_i;
    wire             wvalid_o;
    mm_pkg::word_t   wdata_o;
    wire             wlast_o;
    logic            wready_i;
    logic            bvalid_i;
    wire             bready_o;

    logic [31:0]     lfsr_state = SEED;
    // sparse memory behind the AXI ports
    mm_pkg::word_t   mem_words [mm_pkg::addr_t];
    mm_pkg::word_t   a_mat [16];
    mm_pkg::word_t   b_mat [16];
    mm_pkg::word_t   c_ref [16];
    mm_pkg::addr_t   exp_a;
    mm_pkg::addr_t   exp_b;
    mm_pkg::addr_t   exp_c;
    // open read bursts indexed by id
    logic            r_active [2];
    mm_pkg::addr_t   r_addr [2];
    int              r_beat [2];
    int              w_cnt;
    logic            b_pend;
    int              ar_count;
    int              aw_count;
    int              done_count;

    mm_accel_top dut0 (.*);

    always #10 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic rand_bit();
        lfsr_state = lfsr_step(lfsr_state);
        return lfsr_state[0];
    endfunction

    // one lfsr step per returned bit
    function automatic logic [31:0] rand_bits(input int width);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < width; b++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            report_failure($sformatf("Error: %s got 0x%h expected 0x%h", name, got, expected));
        end
    endtask

    // memory slave with handshakes sampled at the falling edge
    // inputs driven 1 ns after the rising edge
    initial begin : mem_slave
        logic          ar_fire;
        logic          r_fire;
        logic          aw_fire;
        logic          w_fire;
        logic          b_fire;
        logic          id;
        mm_pkg::addr_t addr;
        forever begin
            @(negedge clk);
            if (dut0.chk0.fail_count != 0) begin
                report_failure("protocol assertion failed in the bound checker");
            end
            ar_fire = rst_n && arvalid_o && arready_i;
            r_fire  = rst_n && rvalid_i && rready_o;
            aw_fire = rst_n && awvalid_o && awready_i;
            w_fire  = rst_n && wvalid_o && wready_i;
            b_fire  = rst_n && bvalid_i && bready_o;
            if (ar_fire) begin
                if (ar_count >= 2) begin
                    report_failure("more than two AR transfers in one job");
                end
                check_value("araddr_o", araddr_o, (ar_count == 0) ? exp_a : exp_b);
                check_value("arid_o", arid_o, (ar_count == 0) ? mm_pkg::ID_A : mm_pkg::ID_B);
                r_active[arid_o] = 1'b1;
                r_addr[arid_o]   = araddr_o;
                r_beat[arid_o]   = 0;
                ar_count++;
            end
            if (r_fire) begin
                r_beat[rid_i]++;
                if (r_beat[rid_i] == mm_pkg::BURST_BEATS) begin
                    r_active[rid_i] = 1'b0;
                end
            end
            if (aw_fire) begin
                check_value("awaddr_o", awaddr_o, exp_c);
                aw_count++;
                w_cnt = 0;
            end
            if (w_fire) begin
                if (aw_count == 0 || w_cnt >= mm_pkg::BURST_BEATS) begin
                    report_failure("W beat outside an accepted write burst");
                end
                check_value("wlast_o", wlast_o, w_cnt == mm_pkg::BURST_BEATS - 1);
                mem_words[exp_c + 32'(w_cnt * mm_pkg::WORD_BYTES)] = wdata_o;
                w_cnt++;
                b_pend = wlast_o;
            end
            if (b_fire) begin
                b_pend = 1'b0;
            end
            if (rst_n && done_o) begin
                done_count++;
            end
            @(posedge clk);
            #1;
            arready_i = rand_bit();
            awready_i = rand_bit();
            wready_i  = rand_bit();
            // a presented beat holds until it is taken
            if (!rvalid_i || r_fire) begin
                rvalid_i = 1'b0;
                if ((r_active[0] || r_active[1]) && rand_bit()) begin
                    // interleave at random while both bursts are open
                    if (r_active[0] && r_active[1]) begin
                        id = rand_bit();
                    end else begin
                        id = r_active[1];
                    end
                    addr = r_addr[id] + 32'(r_beat[id] * mm_pkg::WORD_BYTES);
                    if (!mem_words.exists(addr)) begin
                        report_failure("read burst reached an address that holds no data");
                    end
                    rvalid_i = 1'b1;
                    rid_i    = id;
                    rdata_i  = mem_words[addr];
                    rlast_i  = (r_beat[id] == mm_pkg::BURST_BEATS - 1);
                end
            end
            if (!bvalid_i || b_fire) begin
                bvalid_i = b_pend && rand_bit();
            end
        end
    end

    initial begin
        int            cycles;
        mm_pkg::word_t acc;
        clk          = 1'b0;
        rst_n        = 1'b0;
        start_i      = 1'b0;
        mat_a_addr_i = '0;
        mat_b_addr_i = '0;
        mat_c_addr_i = '0;
        arready_i    = 1'b0;
        rvalid_i     = 1'b0;
        rdata_i      = '0;
        rid_i        = 1'b0;
        rlast_i      = 1'b0;
        awready_i    = 1'b0;
        wready_i     = 1'b0;
        bvalid_i     = 1'b0;
        r_active     = '{1'b0, 1'b0};
        r_beat       = '{0, 0};
        w_cnt        = 0;
        b_pend       = 1'b0;
        ar_count     = 0;
        aw_count     = 0;
        done_count   = 0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        // quiet outputs before the first start
        repeat (4) begin
            @(negedge clk);
            check_value("arvalid_o", arvalid_o, 1'b0);
            check_value("rready_o", rready_o, 1'b0);
            check_value("awvalid_o", awvalid_o, 1'b0);
            check_value("wvalid_o", wvalid_o, 1'b0);
            check_value("bready_o", bready_o, 1'b0);
            check_value("done_o", done_o, 1'b0);
        end
        for (int job = 0; job < 8; job++) begin
            @(negedge clk);
            exp_a = rand_bits(20) << 12;
            exp_b = exp_a + 32'h100;
            exp_c = exp_a + 32'h200;
            for (int n = 0; n < 16; n++) begin
                a_mat[n] = rand_bits(32);
                b_mat[n] = rand_bits(32);
            end
            if (job == 0) begin
                // extreme operands for sign and wraparound
                a_mat[0] = 32'h8000_0000;
                b_mat[0] = 32'hffff_ffff;
                a_mat[5] = 32'h7fff_ffff;
                b_mat[5] = 32'h7fff_ffff;
            end
            for (int n = 0; n < 16; n++) begin
                mem_words[exp_a + 32'(n * 4)] = a_mat[n];
                mem_words[exp_b + 32'(n * 4)] = b_mat[n];
            end
            // reference product with 32-bit wraparound
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    acc = '0;
                    for (int k = 0; k < 4; k++) begin
                        acc = acc + a_mat[i * 4 + k] * b_mat[k * 4 + j];
                    end
                    c_ref[i * 4 + j] = acc;
                end
            end
            ar_count = 0;
            aw_count = 0;
            @(posedge clk);
            #1;
            mat_a_addr_i = exp_a;
            mat_b_addr_i = exp_b;
            mat_c_addr_i = exp_c;
            start_i      = 1'b1;
            @(posedge clk);
            #1 start_i = 1'b0;
            cycles = 0;
            while (ar_count < 2) begin
                if (cycles >= TIMEOUT) begin
                    report_failure("timeout waiting for the two AR transfers");
                end
                @(posedge clk);
                cycles++;
            end
            // stray start while loading must be ignored
            #1 start_i = 1'b1;
            @(posedge clk);
            #1 start_i = 1'b0;
            cycles = 0;
            while (done_count == job) begin
                if (cycles >= TIMEOUT) begin
                    report_failure("timeout waiting for done after the write response");
                end
                @(posedge clk);
                cycles++;
            end
            repeat (4) @(posedge clk);
            check_value("aw transfers", aw_count, 1);
            check_value("w beats", w_cnt, 16);
            check_value("done pulses", done_count, job + 1);
            for (int n = 0; n < 16; n++) begin
                check_value($sformatf("c[%0d]", n), mem_words[exp_c + 32'(n * 4)], c_ref[n]);
            end
        end
        if (dut0.chk0.fail_count != 0) begin
            report_failure("protocol assertion failed in the bound checker");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule
`default_nettype wire

// File: verilog/dma_read_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
// read stage of the dma engine
// issues the A and B read bursts, packs r beats into 128-bit rows
// and writes the rows into the two operand buffers
module dma_read_ctrl (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire mm_pkg::addr_t   mat_a_addr_i,
    input  wire mm_pkg::addr_t   mat_b_addr_i,
    input  wire                  start_i,
    input  wire                  job_done_i,
    output logic                 arvalid_o,
    output mm_pkg::addr_t        araddr_o,
    output mm_pkg::axi_id_t      arid_o,
    input  wire                  arready_i,
    input  wire                  rvalid_i,
    input  wire mm_pkg::word_t   rdata_i,
    input  wire mm_pkg::axi_id_t rid_i,
    input  wire                  rlast_i,
    output logic                 rready_o,
    output logic                 buf_a_wren_o,
    output logic                 buf_b_wren_o,
    output mm_pkg::row_addr_t    row_waddr_o,
    output mm_pkg::row_t         row_wdata_o,
    output logic                 load_done_o
);

    mm_pkg::read_state_t state;
    // per-id beat position inside the burst, bits [3:2] give the row
    mm_pkg::beat_cnt_t   beat_a;
    mm_pkg::beat_cnt_t   beat_b;
    mm_pkg::row_t        shift_a;
    mm_pkg::row_t        shift_b;
    // parking spot for a B row that lost the write port
    mm_pkg::row_t        hold_b;
    logic                pend_a;
    logic                pend_b;
    logic                last_a;
    logic                last_b;
    logic                take_a;
    logic                take_b;
    logic                row_end_a;
    logic                row_end_b;

    assign arvalid_o = (state == mm_pkg::RD_AR_A) || (state == mm_pkg::RD_AR_B);
    assign araddr_o  = (state == mm_pkg::RD_AR_B) ? mat_b_addr_i : mat_a_addr_i;
    assign arid_o    = (state == mm_pkg::RD_AR_B) ? mm_pkg::ID_B : mm_pkg::ID_A;
    assign rready_o  = (state == mm_pkg::RD_LOAD);

    // accepted beats split by id
    assign take_a    = rvalid_i && rready_o && (rid_i == mm_pkg::ID_A);
    assign take_b    = rvalid_i && rready_o && (rid_i == mm_pkg::ID_B);
    assign row_end_a = take_a && (beat_a[1:0] == 2'd3);
    assign row_end_b = take_b && (beat_b[1:0] == 2'd3);

    // A has priority on the shared write port
    assign buf_a_wren_o = pend_a;
    assign buf_b_wren_o = pend_b && !pend_a;
    // beat counter already points past the finished row
    assign row_waddr_o  = pend_a ? beat_a[3:2] - 2'd1 : beat_b[3:2] - 2'd1;
    assign row_wdata_o  = pend_a ? shift_a : hold_b;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= mm_pkg::RD_IDLE;
            beat_a      <= '0;
            beat_b      <= '0;
            pend_a      <= 1'b0;
            pend_b      <= 1'b0;
            last_a      <= 1'b0;
            last_b      <= 1'b0;
            load_done_o <= 1'b0;
        end else begin
            load_done_o <= 1'b0;
            pend_a      <= row_end_a;
            // B row stays pending while A owns the port
            pend_b      <= row_end_b || (pend_b && pend_a);
            if (take_a) begin
                beat_a <= beat_a + 4'd1;
                last_a <= last_a || rlast_i;
            end
            if (take_b) begin
                beat_b <= beat_b + 4'd1;
                last_b <= last_b || rlast_i;
            end
            case (state)
                mm_pkg::RD_IDLE: begin
                    if (start_i) begin
                        state  <= mm_pkg::RD_AR_A;
                        beat_a <= '0;
                        beat_b <= '0;
                        last_a <= 1'b0;
                        last_b <= 1'b0;
                    end
                end
                mm_pkg::RD_AR_A: begin
                    if (arready_i) begin
                        state <= mm_pkg::RD_AR_B;
                    end
                end
                mm_pkg::RD_AR_B: begin
                    if (arready_i) begin
                        state <= mm_pkg::RD_LOAD;
                    end
                end
                mm_pkg::RD_LOAD: begin
                    // both bursts seen, final row written this cycle
                    if (last_a && last_b && (pend_a != pend_b)) begin
                        load_done_o <= 1'b1;
                        state       <= mm_pkg::RD_HOLD;
                    end
                end
                mm_pkg::RD_HOLD: begin
                    // buffers reused, wait for the write stage
                    if (job_done_i) begin
                        state <= mm_pkg::RD_IDLE;
                    end
                end
                default: state <= mm_pkg::RD_IDLE;
            endcase
        end
    end

    // first beat of a row ends up in the low word
    always_ff @(posedge clk) begin
        if (take_a) begin
            shift_a <= {rdata_i, shift_a[mm_pkg::ROW_W-1:mm_pkg::WORD_W]};
        end
        if (take_b) begin
            shift_b <= {rdata_i, shift_b[mm_pkg::ROW_W-1:mm_pkg::WORD_W]};
        end
        if (row_end_b) begin
            hold_b <= {rdata_i, shift_b[mm_pkg::ROW_W-1:mm_pkg::WORD_W]};
        end
    end

endmodule
`default_nettype wire

// File: verilog/dma_write_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
// write stage of the dma engine
// sends C as one 16-beat write burst and waits for the response
module dma_write_ctrl (
    input  wire                clk,
    input  wire                rst_n,
    input  wire mm_pkg::addr_t mat_c_addr_i,
    input  wire                mm_done_i,
    input  wire mm_pkg::mat_t  c_words_i,
    output logic               awvalid_o,
    output mm_pkg::addr_t      awaddr_o,
    input  wire                awready_i,
    output logic               wvalid_o,
    output mm_pkg::word_t      wdata_o,
    output logic               wlast_o,
    input  wire                wready_i,
    input  wire                bvalid_i,
    output logic               bready_o,
    output logic               done_o
);

    mm_pkg::write_state_t state;
    // index of the C word on the w channel
    mm_pkg::beat_cnt_t    word_cnt;

    assign awvalid_o = (state == mm_pkg::WR_ADDR);
    assign awaddr_o  = mat_c_addr_i;
    assign wvalid_o  = (state == mm_pkg::WR_DATA);
    // counter only moves on a handshake so data holds under stall
    assign wdata_o   = c_words_i[word_cnt * mm_pkg::WORD_W +: mm_pkg::WORD_W];
    assign wlast_o   = wvalid_o &&
                       (word_cnt == mm_pkg::beat_cnt_t'(mm_pkg::BURST_BEATS - 1));
    assign bready_o  = (state == mm_pkg::WR_RESP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= mm_pkg::WR_IDLE;
            word_cnt <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                mm_pkg::WR_IDLE: begin
                    if (mm_done_i) begin
                        state    <= mm_pkg::WR_ADDR;
                        word_cnt <= '0;
                    end
                end
                mm_pkg::WR_ADDR: begin
                    if (awready_i) begin
                        state <= mm_pkg::WR_DATA;
                    end
                end
                mm_pkg::WR_DATA: begin
                    if (wready_i) begin
                        word_cnt <= word_cnt + 4'd1;
                        if (wlast_o) begin
                            state <= mm_pkg::WR_RESP;
                        end
                    end
                end
                mm_pkg::WR_RESP: begin
                    // bresp not checked
                    if (bvalid_i) begin
                        state  <= mm_pkg::WR_IDLE;
                        done_o <= 1'b1;
                    end
                end
                default: state <= mm_pkg::WR_IDLE;
            endcase
        end
    end

endmodule
`default_nettype wire

// File: verilog/mm_accel_top.sv
`timescale 1ns/1ns
`default_nettype none
// matrix multiply accelerator top
// read stage, two operand buffers, compute stage, write stage
module mm_accel_top (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire mm_pkg::addr_t   mat_a_addr_i,
    input  wire mm_pkg::addr_t   mat_b_addr_i,
    input  wire mm_pkg::addr_t   mat_c_addr_i,
    input  wire                  start_i,
    output wire                  done_o,
    output wire                  arvalid_o,
    output wire mm_pkg::addr_t   araddr_o,
    output wire mm_pkg::axi_id_t arid_o,
    input  wire                  arready_i,
    input  wire                  rvalid_i,
    input  wire mm_pkg::word_t   rdata_i,
    input  wire mm_pkg::axi_id_t rid_i,
    input  wire                  rlast_i,
    output wire                  rready_o,
    output wire                  awvalid_o,
    output wire mm_pkg::addr_t   awaddr_o,
    input  wire                  awready_i,
    output wire                  wvalid_o,
    output wire mm_pkg::word_t   wdata_o,
    output wire                  wlast_o,
    input  wire                  wready_i,
    input  wire                  bvalid_i,
    output wire                  bready_o
);

    // buffer write side, shared by A and B
    wire                    buf_a_wren;
    wire                    buf_b_wren;
    wire mm_pkg::row_addr_t row_waddr;
    wire mm_pkg::row_t      row_wdata;
    // buffer read side
    wire mm_pkg::row_addr_t a_raddr;
    wire mm_pkg::row_addr_t b_raddr;
    wire mm_pkg::row_t      a_row;
    wire mm_pkg::row_t      b_row;
    // stage hand-offs
    wire                    load_done;
    wire                    mm_done;
    wire mm_pkg::mat_t      c_words;

    // done_o also frees the read stage for the next job
    dma_read_ctrl read0 (
        .*,
        .job_done_i   (done_o),
        .buf_a_wren_o (buf_a_wren),
        .buf_b_wren_o (buf_b_wren),
        .row_waddr_o  (row_waddr),
        .row_wdata_o  (row_wdata),
        .load_done_o  (load_done)
    );

    row_buffer buf_a0 (
        .clk     (clk),
        .wren_i  (buf_a_wren),
        .waddr_i (row_waddr),
        .wdata_i (row_wdata),
        .raddr_i (a_raddr),
        .rdata_o (a_row)
    );

    row_buffer buf_b0 (
        .clk     (clk),
        .wren_i  (buf_b_wren),
        .waddr_i (row_waddr),
        .wdata_i (row_wdata),
        .raddr_i (b_raddr),
        .rdata_o (b_row)
    );

    mm_engine engine0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_done_i (load_done),
        .a_raddr_o   (a_raddr),
        .b_raddr_o   (b_raddr),
        .a_row_i     (a_row),
        .b_row_i     (b_row),
        .mm_done_o   (mm_done),
        .c_words_o   (c_words)
    );

    dma_write_ctrl write0 (
        .*,
        .mm_done_i (mm_done),
        .c_words_i (c_words)
    );

endmodule
`default_nettype wire

// File: verilog/mm_engine.sv
`timescale 1ns/1ns
`default_nettype none
// compute stage, C = A x B on 4x4 words
// one A row and one B row per step, four multiply-accumulates in parallel
module mm_engine (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    load_done_i,
    output mm_pkg::row_addr_t      a_raddr_o,
    output mm_pkg::row_addr_t      b_raddr_o,
    input  wire mm_pkg::row_t      a_row_i,
    input  wire mm_pkg::row_t      b_row_i,
    output logic                   mm_done_o,
    output mm_pkg::mat_t           c_words_o
);

    mm_pkg::mm_state_t state;
    // step = {row i, inner index k}
    mm_pkg::beat_cnt_t step;
    // step matching the rows on the buffer outputs
    mm_pkg::beat_cnt_t step_d;
    logic              acc_en;
    mm_pkg::word_t     a_elem;
    mm_pkg::word_t     acc [mm_pkg::MAT_DIM * mm_pkg::MAT_DIM];

    assign a_raddr_o = step[3:2];
    assign b_raddr_o = step[1:0];

    // A[i][k] out of the A row
    assign a_elem = a_row_i[step_d[1:0] * mm_pkg::WORD_W +: mm_pkg::WORD_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= mm_pkg::MM_IDLE;
            step      <= '0;
            acc_en    <= 1'b0;
            mm_done_o <= 1'b0;
        end else begin
            mm_done_o <= 1'b0;
            // buffer read latency of one cycle
            acc_en    <= (state == mm_pkg::MM_RUN);
            case (state)
                mm_pkg::MM_IDLE: begin
                    if (load_done_i) begin
                        state <= mm_pkg::MM_RUN;
                        step  <= '0;
                    end
                end
                mm_pkg::MM_RUN: begin
                    step <= step + 4'd1;
                    if (step == mm_pkg::beat_cnt_t'(mm_pkg::BURST_BEATS - 1)) begin
                        state <= mm_pkg::MM_FLUSH;
                    end
                end
                mm_pkg::MM_FLUSH: begin
                    // last step accumulates here
                    state     <= mm_pkg::MM_IDLE;
                    mm_done_o <= 1'b1;
                end
                default: state <= mm_pkg::MM_IDLE;
            endcase
        end
    end

    // products and sums wrap at 32 bits
    always_ff @(posedge clk) begin
        step_d <= step;
        if (load_done_i) begin
            for (int n = 0; n < mm_pkg::MAT_DIM * mm_pkg::MAT_DIM; n++) begin
                acc[n] <= '0;
            end
        end else if (acc_en) begin
            for (int j = 0; j < mm_pkg::MAT_DIM; j++) begin
                acc[step_d[3:2] * mm_pkg::MAT_DIM + j] <=
                    acc[step_d[3:2] * mm_pkg::MAT_DIM + j] +
                    a_elem * b_row_i[j * mm_pkg::WORD_W +: mm_pkg::WORD_W];
            end
        end
    end

    // row-major flat view for the write stage
    always_comb begin
        for (int n = 0; n < mm_pkg::MAT_DIM * mm_pkg::MAT_DIM; n++) begin
            c_words_o[n * mm_pkg::WORD_W +: mm_pkg::WORD_W] = acc[n];
        end
    end

endmodule
`default_nettype wire

// File: verilog/mm_pkg.sv
`default_nettype none
// matrix multiply accelerator shared definitions
// fixed 4x4 matrices of 32-bit words, one 16-beat burst per matrix
package mm_pkg;

    localparam int unsigned MAT_DIM     = 4;
    localparam int unsigned BURST_BEATS = 16;
    localparam int unsigned WORD_BYTES  = 4;
    localparam int unsigned WORD_W      = WORD_BYTES * 8;
    localparam int unsigned ROW_W       = MAT_DIM * WORD_W;
    localparam int unsigned MAT_W       = MAT_DIM * ROW_W;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [31:0]       addr_t;
    typedef logic [ROW_W-1:0]  row_t;
    // sixteen words, row-major, word 0 in the low bits
    typedef logic [MAT_W-1:0]  mat_t;
    typedef logic [1:0]        row_addr_t;
    typedef logic [3:0]        beat_cnt_t;
    typedef logic              axi_id_t;

    // read ids, r beats are routed by these
    localparam axi_id_t ID_A = 1'b0;
    localparam axi_id_t ID_B = 1'b1;

    typedef enum logic [2:0] {
        RD_IDLE,
        RD_AR_A,
        RD_AR_B,
        RD_LOAD,
        RD_HOLD
    } read_state_t;

    typedef enum logic [1:0] {
        MM_IDLE,
        MM_RUN,
        MM_FLUSH
    } mm_state_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } write_state_t;

endpackage
`default_nettype wire

// File: verilog/row_buffer.sv
`timescale 1ns/1ns
`default_nettype none
// operand row buffer
// four 128-bit rows, one write port, one registered read port
module row_buffer (
    input  wire                    clk,
    input  wire                    wren_i,
    input  wire mm_pkg::row_addr_t waddr_i,
    input  wire mm_pkg::row_t      wdata_i,
    input  wire mm_pkg::row_addr_t raddr_i,
    output mm_pkg::row_t           rdata_o
);

    // one entry per matrix row
    mm_pkg::row_t mem [mm_pkg::MAT_DIM];

    always_ff @(posedge clk) begin
        if (wren_i) begin
            mem[waddr_i] <= wdata_i;
        end
        // read data lands one cycle after the address
        rdata_o <= mem[raddr_i];
    end

endmodule
`default_nettype wire

// File: vlog.f
verilog/mm_pkg.sv
verilog/row_buffer.sv
verilog/dma_read_ctrl.sv
verilog/mm_engine.sv
verilog/dma_write_ctrl.sv
verilog/mm_accel_top.sv
sim/mm_accel_checker.sv
sim/tb_mm_accel.sv
